//--- logic/cu_pkg.sv
package cu_pkg;

    localparam int OPCODE_W = 6;
    localparam int FUNCT_W = 6;

    // Wait lengths in cycles
    localparam int FETCH_WAIT = 2;
    localparam int MEM_WAIT = 2;
    localparam int EXC_WAIT = 8;
    localparam int WAIT_W = 4;

    // ALU operand A sources
    localparam logic [1:0] SRC_A_PC = 2'd0;
    localparam logic [1:0] SRC_A_REG = 2'd1;

    // ALU operand B sources
    localparam logic [2:0] SRC_B_REG = 3'd0;
    localparam logic [2:0] SRC_B_FOUR = 3'd1;
    localparam logic [2:0] SRC_B_IMM = 3'd2;

    // Memory address sources
    localparam logic [2:0] IORD_PC = 3'd0;
    localparam logic [2:0] IORD_ALU = 3'd1;
    localparam logic [2:0] IORD_VECTOR = 3'd2;

    typedef enum logic [OPCODE_W-1:0] {
        op_rtype = 6'h00,
        op_j = 6'h02,
        op_jal = 6'h03,
        op_addi = 6'h08,
        op_addiu = 6'h09,
        op_lb = 6'h20,
        op_lh = 6'h21,
        op_lw = 6'h23,
        op_sb = 6'h28,
        op_sh = 6'h29,
        op_sw = 6'h2b
    } opcode_e;

    typedef enum logic [FUNCT_W-1:0] {
        fn_jr = 6'h08,
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24
    } funct_e;

    typedef enum logic [3:0] {
        insn_add, insn_sub, insn_and,
        insn_addi, insn_addiu,
        insn_lw, insn_lh, insn_lb,
        insn_sw, insn_sh, insn_sb,
        insn_j, insn_jal, insn_jr,
        insn_illegal
    } insn_e;

    typedef enum logic [4:0] {
        st_reset_stack,
        st_fetch_wait, st_fetch_latch,
        st_decode_regs, st_decode_dispatch,
        st_alu_reg, st_alu_imm,
        st_write_rd, st_write_rt_checked, st_write_rt,
        st_load_addr, st_mem_read, st_mdr_select, st_load_write,
        st_store_addr, st_store_write,
        st_jump, st_jal_link, st_link_write, st_jump_reg,
        st_exc_illegal, st_exc_overflow, st_exc_commit
    } step_e;

    typedef enum logic [2:0] {alu_pass = 3'd0, alu_add = 3'd1, alu_sub = 3'd2, alu_and = 3'd3} alu_op_e;
    typedef enum logic [2:0] {pc_alu = 3'd0, pc_jump = 3'd2, pc_vector = 3'd3} pc_src_e;
    typedef enum logic [1:0] {width_word = 2'd0, width_half = 2'd1, width_byte = 2'd2} width_e;
    typedef enum logic [1:0] {dst_rt = 2'd0, dst_rd = 2'd1, dst_stack = 2'd2, dst_ra = 2'd3} reg_dst_e;
    typedef enum logic [3:0] {m2r_alu = 4'd0, m2r_mdr = 4'd1, m2r_stack = 4'd4} mem_to_reg_e;
    typedef enum logic [1:0] {exc_code_illegal = 2'd0, exc_code_overflow = 2'd1} except_e;

    typedef struct packed {
        logic pc_write;
        logic branch;
        logic mem_wr;
        logic ir_write;
        logic a_write;
        logic b_write;
        logic mdr_write;
        logic alu_reg_write;
        logic epc_write;
        logic reg_write;
        logic [1:0] spare;      // Always zero
    } ctrl_strobes_t;

    typedef struct packed {
        reg_dst_e reg_dst;
        except_e except;
        width_e mem_to_mdr;     // Load width
        width_e b_to_c;         // Store width
        logic [1:0] alu_src_a;
        logic [2:0] iord;
        logic [2:0] alu_src_b;
        alu_op_e alu_op;
        pc_src_e pc_src;
        mem_to_reg_e mem_to_reg;
    } ctrl_selects_t;

    localparam ctrl_strobes_t STROBES_IDLE = '0;
    localparam ctrl_selects_t SELECTS_IDLE = '0;

endpackage

//--- logic/insn_decoder.sv
`timescale 1ns/10ps

module insn_decoder (
    input  logic [cu_pkg::OPCODE_W-1:0] opcode,
    input  logic [cu_pkg::FUNCT_W-1:0] funct,
    output cu_pkg::insn_e insn
);
    import cu_pkg::*;

    opcode_e op;
    funct_e fn;

    assign op = opcode_e'(opcode);
    assign fn = funct_e'(funct);

    always_comb begin
        case (op)
            op_rtype: begin
                // R-type split on funct
                case (fn)
                    fn_add: insn = insn_add;
                    fn_sub: insn = insn_sub;
                    fn_and: insn = insn_and;
                    fn_jr: insn = insn_jr;
                    default: insn = insn_illegal;
                endcase
            end
            op_addi: insn = insn_addi;
            op_addiu: insn = insn_addiu;
            op_lw: insn = insn_lw;
            op_lh: insn = insn_lh;
            op_lb: insn = insn_lb;
            op_sw: insn = insn_sw;
            op_sh: insn = insn_sh;
            op_sb: insn = insn_sb;
            op_j: insn = insn_j;
            op_jal: insn = insn_jal;
            default: insn = insn_illegal;   // Unknown or dropped encodings
        endcase
    end

endmodule

//--- logic/cycle_sequencer.sv
`timescale 1ns/10ps

module cycle_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic ov,
    input  cu_pkg::insn_e insn,
    output cu_pkg::step_e step
);
    import cu_pkg::*;

    step_e next_step;
    logic [WAIT_W-1:0] wait_cnt;
    logic [WAIT_W-1:0] step_wait;   // Length of the current step
    logic wait_done;

    always_comb begin
        case (step)
            st_fetch_wait: step_wait = WAIT_W'(FETCH_WAIT);
            st_mem_read: step_wait = WAIT_W'(MEM_WAIT);
            st_exc_illegal, st_exc_overflow: step_wait = WAIT_W'(EXC_WAIT);
            default: step_wait = WAIT_W'(1);
        endcase
    end

    assign wait_done = (wait_cnt == step_wait - 1'b1);

    always_comb begin
        next_step = st_fetch_wait;
        case (step)
            st_reset_stack: next_step = st_fetch_wait;
            st_fetch_wait: begin
                next_step = wait_done ? st_fetch_latch : st_fetch_wait;
            end
            st_fetch_latch: next_step = st_decode_regs;
            st_decode_regs: next_step = st_decode_dispatch;
            st_decode_dispatch: begin
                case (insn)
                    insn_add, insn_sub, insn_and: next_step = st_alu_reg;
                    insn_addi, insn_addiu: next_step = st_alu_imm;
                    insn_lw, insn_lh, insn_lb: next_step = st_load_addr;
                    insn_sw, insn_sh, insn_sb: next_step = st_store_addr;
                    insn_j: next_step = st_jump;
                    insn_jal: next_step = st_jal_link;
                    insn_jr: next_step = st_jump_reg;
                    default: next_step = st_exc_illegal;
                endcase
            end

            st_alu_reg: next_step = st_write_rd;
            st_alu_imm: begin
                // addiu never traps
                next_step = (insn == insn_addi) ? st_write_rt_checked : st_write_rt;
            end
            st_write_rd, st_write_rt_checked: begin
                next_step = ov ? st_exc_overflow : st_fetch_wait;
            end
            st_write_rt: next_step = st_fetch_wait;

            st_load_addr: next_step = st_mem_read;
            st_mem_read: begin
                next_step = wait_done ? st_mdr_select : st_mem_read;
            end
            st_mdr_select: next_step = st_load_write;
            st_load_write: next_step = st_fetch_wait;

            st_store_addr: next_step = st_store_write;
            st_store_write: next_step = st_fetch_wait;

            st_jump: next_step = st_fetch_wait;
            st_jal_link: next_step = st_link_write;
            st_link_write: next_step = st_fetch_wait;
            st_jump_reg: next_step = st_fetch_wait;

            st_exc_illegal: begin
                next_step = wait_done ? st_exc_commit : st_exc_illegal;
            end
            st_exc_overflow: begin
                next_step = wait_done ? st_exc_commit : st_exc_overflow;
            end
            st_exc_commit: next_step = st_fetch_wait;
            default: next_step = st_fetch_wait;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            step <= st_reset_stack;
            wait_cnt <= '0;
        end else begin
            step <= next_step;
            if (next_step != step) begin
                wait_cnt <= '0;     // Fresh count on entry
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

endmodule

//--- logic/control_encoder.sv
`timescale 1ns/10ps

module control_encoder (
    input  cu_pkg::step_e step,
    input  cu_pkg::insn_e insn,
    input  logic ov,
    output cu_pkg::ctrl_strobes_t strobes,
    output cu_pkg::ctrl_selects_t selects
);
    import cu_pkg::*;

    function automatic width_e width_of(insn_e cls);
        case (cls)
            insn_lh, insn_sh: return width_half;
            insn_lb, insn_sb: return width_byte;
            default: return width_word;
        endcase
    endfunction

    function automatic alu_op_e rtype_op(insn_e cls);
        case (cls)
            insn_sub: return alu_sub;
            insn_and: return alu_and;
            default: return alu_add;
        endcase
    endfunction

    always_comb begin
        strobes = STROBES_IDLE;
        selects = SELECTS_IDLE;
        case (step)
            st_reset_stack: begin
                // Clear the stack-top register
                strobes.reg_write = 1'b1;
                selects.reg_dst = dst_stack;
                selects.mem_to_reg = m2r_stack;
            end
            st_fetch_wait, st_fetch_latch, st_decode_regs: begin
                selects.iord = IORD_PC;
                selects.alu_src_a = SRC_A_PC;     // PC + 4
                selects.alu_src_b = SRC_B_FOUR;
                selects.alu_op = alu_add;
                strobes.pc_write = (step == st_fetch_latch);
                strobes.ir_write = (step == st_fetch_latch);
                strobes.a_write = (step == st_decode_regs);
                strobes.b_write = (step == st_decode_regs);
            end
            st_alu_reg, st_alu_imm, st_load_addr, st_store_addr: begin
                selects.alu_src_a = SRC_A_REG;
                selects.alu_src_b = (step == st_alu_reg) ? SRC_B_REG : SRC_B_IMM;
                selects.alu_op = (step == st_alu_reg) ? rtype_op(insn) : alu_add;
                strobes.alu_reg_write = 1'b1;
            end
            st_write_rd, st_write_rt_checked, st_write_rt: begin
                // Checked writes are dropped on overflow
                strobes.reg_write = (step == st_write_rt) ? 1'b1 : !ov;
                selects.reg_dst = (step == st_write_rd) ? dst_rd : dst_rt;
                selects.mem_to_reg = m2r_alu;
            end
            st_mem_read: selects.iord = IORD_ALU;
            st_mdr_select: begin
                selects.iord = IORD_ALU;
                selects.mem_to_mdr = width_of(insn);
                strobes.mdr_write = 1'b1;
            end
            st_load_write: begin
                strobes.reg_write = 1'b1;
                selects.reg_dst = dst_rt;
                selects.mem_to_reg = m2r_mdr;
            end
            st_store_write: begin
                selects.iord = IORD_ALU;
                selects.b_to_c = width_of(insn);
                strobes.mem_wr = 1'b1;
            end
            st_jal_link: begin
                selects.alu_src_a = SRC_A_PC;   // Return address via ALU pass
                selects.alu_op = alu_pass;
                strobes.alu_reg_write = 1'b1;
            end
            st_jump, st_link_write, st_jump_reg: begin
                strobes.pc_write = 1'b1;
                strobes.branch = 1'b1;
                selects.pc_src = (step == st_jump_reg) ? pc_alu : pc_jump;
                selects.alu_src_a = SRC_A_REG;
                selects.alu_op = alu_pass;
                strobes.reg_write = (step == st_link_write);
                selects.reg_dst = (step == st_link_write) ? dst_ra : dst_rt;
                selects.mem_to_reg = m2r_alu;
            end
            st_exc_illegal, st_exc_overflow, st_exc_commit: begin
                selects.except = (insn == insn_illegal) ? exc_code_illegal : exc_code_overflow;
                selects.iord = IORD_VECTOR;
                selects.alu_src_a = SRC_A_PC;     // EPC gets PC - 4
                selects.alu_src_b = SRC_B_FOUR;
                selects.alu_op = alu_sub;
                selects.pc_src = pc_vector;
                strobes.epc_write = (step == st_exc_commit);
                strobes.pc_write = (step == st_exc_commit);
            end
            default: begin
                strobes = STROBES_IDLE;
                selects = SELECTS_IDLE;
            end
        endcase
    end

endmodule

//--- logic/control_unit.sv
`timescale 1ns/10ps

module control_unit (
    input  logic clk,
    input  logic reset,
    input  logic ov,
    input  logic [cu_pkg::OPCODE_W-1:0] opcode,
    input  logic [cu_pkg::FUNCT_W-1:0] funct,
    output cu_pkg::ctrl_strobes_t strobes,
    output cu_pkg::ctrl_selects_t selects
);
    import cu_pkg::*;

    insn_e insn;
    step_e step;

    insn_decoder u_decoder (
        .opcode(opcode),
        .funct(funct),
        .insn(insn)
    );

    cycle_sequencer u_sequencer (
        .clk(clk),
        .reset(reset),
        .ov(ov),
        .insn(insn),
        .step(step)
    );

    control_encoder u_encoder (
        .step(step),
        .insn(insn),
        .ov(ov),
        .strobes(strobes),
        .selects(selects)
    );

endmodule

//--- verification/cu_model.svh
`ifndef CU_MODEL_SVH
`define CU_MODEL_SVH

step_e m_step;
int m_cnt;

function automatic insn_e decode_class(logic [OPCODE_W-1:0] op, logic [FUNCT_W-1:0] fn);
    case (op)
        op_rtype: begin
            case (fn)
                fn_add: return insn_add;
                fn_sub: return insn_sub;
                fn_and: return insn_and;
                fn_jr: return insn_jr;
                default: return insn_illegal;
            endcase
        end
        op_addi: return insn_addi;
        op_addiu: return insn_addiu;
        op_lw: return insn_lw;
        op_lh: return insn_lh;
        op_lb: return insn_lb;
        op_sw: return insn_sw;
        op_sh: return insn_sh;
        op_sb: return insn_sb;
        op_j: return insn_j;
        op_jal: return insn_jal;
        default: return insn_illegal;
    endcase
endfunction

function automatic int step_length(step_e s);
    case (s)
        st_fetch_wait: return FETCH_WAIT;
        st_mem_read: return MEM_WAIT;
        st_exc_illegal, st_exc_overflow: return EXC_WAIT;
        default: return 1;
    endcase
endfunction

function automatic step_e step_after(step_e s, int cnt, insn_e c, logic ov_in);
    logic done;
    done = (cnt == step_length(s) - 1);
    case (s)
        st_fetch_wait: return done ? st_fetch_latch : st_fetch_wait;
        st_fetch_latch: return st_decode_regs;
        st_decode_regs: return st_decode_dispatch;
        st_decode_dispatch: begin
            case (c)
                insn_add, insn_sub, insn_and: return st_alu_reg;
                insn_addi, insn_addiu: return st_alu_imm;
                insn_lw, insn_lh, insn_lb: return st_load_addr;
                insn_sw, insn_sh, insn_sb: return st_store_addr;
                insn_j: return st_jump;
                insn_jal: return st_jal_link;
                insn_jr: return st_jump_reg;
                default: return st_exc_illegal;
            endcase
        end
        st_alu_reg: return st_write_rd;
        st_alu_imm: return (c == insn_addi) ? st_write_rt_checked : st_write_rt;
        st_write_rd, st_write_rt_checked: return ov_in ? st_exc_overflow : st_fetch_wait;
        st_load_addr: return st_mem_read;
        st_mem_read: return done ? st_mdr_select : st_mem_read;
        st_mdr_select: return st_load_write;
        st_store_addr: return st_store_write;
        st_jal_link: return st_link_write;
        st_exc_illegal: return done ? st_exc_commit : st_exc_illegal;
        st_exc_overflow: return done ? st_exc_commit : st_exc_overflow;
        default: return st_fetch_wait;
    endcase
endfunction

task automatic model_clock(logic rst, insn_e c, logic ov_in);
    step_e nxt;
    nxt = rst ? st_reset_stack : step_after(m_step, m_cnt, c, ov_in);
    m_cnt = (rst || nxt != m_step) ? 0 : m_cnt + 1;
    m_step = nxt;
endtask

function automatic width_e class_width(insn_e c);
    if (c == insn_lh || c == insn_sh) return width_half;
    if (c == insn_lb || c == insn_sb) return width_byte;
    return width_word;
endfunction

// Expected datapath controls for one step
task automatic expect_controls(step_e s, insn_e c, logic ov_in,
                               output ctrl_strobes_t st, output ctrl_selects_t se);
    st = '0;
    se = '0;
    case (s)
        st_reset_stack: begin
            st.reg_write = 1'b1;
            se.reg_dst = dst_stack;
            se.mem_to_reg = m2r_stack;
        end
        st_fetch_wait, st_fetch_latch, st_decode_regs: begin
            se.alu_src_b = 3'd1;    // Constant four
            se.alu_op = alu_add;
            st.pc_write = (s == st_fetch_latch);
            st.ir_write = (s == st_fetch_latch);
            st.a_write = (s == st_decode_regs);
            st.b_write = (s == st_decode_regs);
        end
        st_alu_reg: begin
            se.alu_src_a = 2'd1;
            se.alu_op = (c == insn_sub) ? alu_sub : ((c == insn_and) ? alu_and : alu_add);
            st.alu_reg_write = 1'b1;
        end
        st_alu_imm, st_load_addr, st_store_addr: begin
            se.alu_src_a = 2'd1;
            se.alu_src_b = 3'd2;    // Immediate
            se.alu_op = alu_add;
            st.alu_reg_write = 1'b1;
        end
        st_write_rd, st_write_rt_checked, st_write_rt: begin
            st.reg_write = (s == st_write_rt) || !ov_in;
            se.reg_dst = (s == st_write_rd) ? dst_rd : dst_rt;
        end
        st_mem_read: se.iord = 3'd1;
        st_mdr_select: begin
            se.iord = 3'd1;
            se.mem_to_mdr = class_width(c);
            st.mdr_write = 1'b1;
        end
        st_load_write: begin
            st.reg_write = 1'b1;
            se.mem_to_reg = m2r_mdr;
        end
        st_store_write: begin
            se.iord = 3'd1;
            se.b_to_c = class_width(c);
            st.mem_wr = 1'b1;
        end
        st_jal_link: begin
            se.alu_op = alu_pass;
            st.alu_reg_write = 1'b1;
        end
        st_jump, st_link_write, st_jump_reg: begin
            st.pc_write = 1'b1;
            st.branch = 1'b1;
            st.reg_write = (s == st_link_write);
            se.pc_src = (s == st_jump_reg) ? pc_alu : pc_jump;
            se.alu_src_a = 2'd1;
            se.alu_op = alu_pass;
            se.reg_dst = (s == st_link_write) ? dst_ra : dst_rt;
        end
        st_exc_illegal, st_exc_overflow, st_exc_commit: begin
            se.except = (c == insn_illegal) ? exc_code_illegal : exc_code_overflow;
            se.iord = 3'd2;         // Vector
            se.alu_src_b = 3'd1;
            se.alu_op = alu_sub;
            se.pc_src = pc_vector;
            st.epc_write = (s == st_exc_commit);
            st.pc_write = (s == st_exc_commit);
        end
        default: ;
    endcase
endtask

`endif

//--- verification/control_unit_tb.sv
`timescale 1ns/10ps

module control_unit_tb;
    import cu_pkg::*;

    localparam int NUM_INSNS = 400;
    localparam int INSN_TIMEOUT = 40;

    logic clk;
    logic reset;
    logic ov;
    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT_W-1:0] funct;
    ctrl_strobes_t strobes;
    ctrl_selects_t selects;
    logic [31:0] lcg_state;
    int reset_left;
    int strobe_errors;
    int select_errors;
    int cycles;
    bit timed_out;

    `include "cu_model.svh"

    control_unit uut (
        .clk(clk),
        .reset(reset),
        .ov(ov),
        .opcode(opcode),
        .funct(funct),
        .strobes(strobes),
        .selects(selects)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [11:0] kept_encoding(int idx, logic [5:0] rnd_fn);
        case (idx)
            0: return {op_rtype, fn_add};
            1: return {op_rtype, fn_sub};
            2: return {op_rtype, fn_and};
            3: return {op_rtype, fn_jr};
            4: return {op_addi, rnd_fn};
            5: return {op_addiu, rnd_fn};
            6: return {op_lw, rnd_fn};
            7: return {op_lh, rnd_fn};
            8: return {op_lb, rnd_fn};
            9: return {op_sw, rnd_fn};
            10: return {op_sh, rnd_fn};
            11: return {op_sb, rnd_fn};
            12: return {op_j, rnd_fn};
            default: return {op_jal, rnd_fn};
        endcase
    endfunction

    task automatic draw_instruction();
        logic [31:0] r;
        r = next_random();
        if (r[17:16] != 2'b00) begin
            {opcode, funct} = kept_encoding(int'(r[27:20]) % 14, r[13:8]);
        end else begin
            {opcode, funct} = {r[29:24], r[13:8]};  // Any encoding
        end
    endtask

    function automatic bit field_differs(string name, logic [7:0] exp, logic [7:0] act);
        if (exp !== act) begin
            $display("error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic check_strobes(ctrl_strobes_t exp, ctrl_strobes_t act);
        if (field_differs("pc_write", 8'(exp.pc_write), 8'(act.pc_write))) strobe_errors++;
        if (field_differs("branch", 8'(exp.branch), 8'(act.branch))) strobe_errors++;
        if (field_differs("mem_wr", 8'(exp.mem_wr), 8'(act.mem_wr))) strobe_errors++;
        if (field_differs("ir_write", 8'(exp.ir_write), 8'(act.ir_write))) strobe_errors++;
        if (field_differs("a_write", 8'(exp.a_write), 8'(act.a_write))) strobe_errors++;
        if (field_differs("b_write", 8'(exp.b_write), 8'(act.b_write))) strobe_errors++;
        if (field_differs("mdr_write", 8'(exp.mdr_write), 8'(act.mdr_write))) strobe_errors++;
        if (field_differs("alu_reg_write", 8'(exp.alu_reg_write), 8'(act.alu_reg_write)))
            strobe_errors++;
        if (field_differs("epc_write", 8'(exp.epc_write), 8'(act.epc_write))) strobe_errors++;
        if (field_differs("reg_write", 8'(exp.reg_write), 8'(act.reg_write))) strobe_errors++;
        if (field_differs("spare", 8'(exp.spare), 8'(act.spare))) strobe_errors++;
    endtask

    task automatic check_selects(ctrl_selects_t exp, ctrl_selects_t act);
        if (field_differs("reg_dst", 8'(exp.reg_dst), 8'(act.reg_dst))) select_errors++;
        if (field_differs("except", 8'(exp.except), 8'(act.except))) select_errors++;
        if (field_differs("mem_to_mdr", 8'(exp.mem_to_mdr), 8'(act.mem_to_mdr))) select_errors++;
        if (field_differs("b_to_c", 8'(exp.b_to_c), 8'(act.b_to_c))) select_errors++;
        if (field_differs("alu_src_a", 8'(exp.alu_src_a), 8'(act.alu_src_a))) select_errors++;
        if (field_differs("iord", 8'(exp.iord), 8'(act.iord))) select_errors++;
        if (field_differs("alu_src_b", 8'(exp.alu_src_b), 8'(act.alu_src_b))) select_errors++;
        if (field_differs("alu_op", 8'(exp.alu_op), 8'(act.alu_op))) select_errors++;
        if (field_differs("pc_src", 8'(exp.pc_src), 8'(act.pc_src))) select_errors++;
        if (field_differs("mem_to_reg", 8'(exp.mem_to_reg), 8'(act.mem_to_reg))) select_errors++;
    endtask

    // One clock: advance the model, drive inputs, check mid-cycle
    task automatic run_cycle();
        ctrl_strobes_t exp_st;
        ctrl_selects_t exp_se;
        logic [31:0] r;
        @(posedge clk);
        model_clock(reset, decode_class(opcode, funct), ov);
        #2;
        if (reset_left > 0) reset_left--;
        reset = (reset_left > 0);
        r = next_random();
        ov = r[20];
        if (m_step == st_fetch_latch) draw_instruction();
        #18;
        expect_controls(m_step, decode_class(opcode, funct), ov, exp_st, exp_se);
        check_strobes(exp_st, strobes);
        check_selects(exp_se, selects);
    endtask

    initial begin
        reset = 1'b1;
        ov = 1'b0;
        opcode = op_rtype;
        funct = fn_add;
        lcg_state = 32'd41589;
        reset_left = 3;
        strobe_errors = 0;
        select_errors = 0;
        timed_out = 1'b0;
        m_cnt = 0;
        repeat (3) run_cycle();
        for (int n = 0; n < NUM_INSNS; n++) begin
            cycles = 1;
            run_cycle();
            // IR write marks the next fetch latch
            while (strobes.ir_write !== 1'b1 && cycles < INSN_TIMEOUT) begin
                run_cycle();
                cycles++;
            end
            if (strobes.ir_write !== 1'b1) begin
                $display("Instruction %0d did not reach the next fetch in time", n);
                timed_out = 1'b1;
                break;
            end
        end
        $display("Errors: %0d strobe, %0d select", strobe_errors, select_errors);
        if (!timed_out && strobe_errors == 0 && select_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- multicycle_cu.f
+incdir+verification
logic/cu_pkg.sv
logic/insn_decoder.sv
logic/cycle_sequencer.sv
logic/control_encoder.sv
logic/control_unit.sv
verification/control_unit_tb.sv

//--- Makefile
TB_BIN = obj_dir/Vcontrol_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only logic/cu_pkg.sv logic/insn_decoder.sv logic/cycle_sequencer.sv \
		logic/control_encoder.sv logic/control_unit.sv --top-module control_unit

sim:
	verilator --binary --timing -f multicycle_cu.f --top-module control_unit_tb
	out=$$(./$(TB_BIN)); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
